/* common/arp_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types and protocol constants for the ARP core.
// Imported by the handler, cache, resolver, arbiter and top,
// and by the testbench for the resolver state encoding.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package arp_pkg;

    // address and field widths
    typedef logic [47:0] mac_addr_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] arp_oper_t;
    typedef logic [15:0] eth_type_t;

    // resolver FSM
    typedef enum logic [1:0] {
        RES_IDLE    = 2'd0,
        RES_QUERY   = 2'd1,
        RES_PENDING = 2'd2
    } resolver_state_t;

    // ARP over Ethernet for IPv4
    localparam eth_type_t ETHERTYPE_ARP  = 16'h0806;
    localparam arp_oper_t HTYPE_ETHERNET = 16'h0001;
    localparam arp_oper_t PTYPE_IPV4     = 16'h0800;

    // operation codes
    localparam arp_oper_t OPER_REQUEST = 16'h0001;
    localparam arp_oper_t OPER_REPLY   = 16'h0002;

    // special addresses
    localparam mac_addr_t MAC_BROADCAST = 48'hffff_ffff_ffff;
    localparam mac_addr_t MAC_ZERO      = 48'h0000_0000_0000;
    localparam ip_addr_t  IP_BROADCAST  = 32'hffff_ffff;

endpackage

/* arp/arp_frame_handler.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Incoming ARP frame handler. Checks the protocol fields of
// each parsed frame, learns the sender pair into the cache
// and raises a reply for requests aimed at the local IP.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module arp_frame_handler (
    input  logic               clk,
    input  logic               rst_n,
    input  arp_pkg::ip_addr_t  local_ip,
    input  logic               rx_valid,
    input  arp_pkg::mac_addr_t rx_eth_src_mac,
    input  arp_pkg::eth_type_t rx_eth_type,
    input  arp_pkg::arp_oper_t rx_htype,
    input  arp_pkg::arp_oper_t rx_ptype,
    input  arp_pkg::arp_oper_t rx_oper,
    input  arp_pkg::mac_addr_t rx_sha,
    input  arp_pkg::ip_addr_t  rx_spa,
    input  arp_pkg::ip_addr_t  rx_tpa,
    output logic               wr_valid,
    output arp_pkg::ip_addr_t  wr_ip,
    output arp_pkg::mac_addr_t wr_mac,
    output logic               reply_valid,
    output arp_pkg::mac_addr_t reply_dest_mac,
    output arp_pkg::ip_addr_t  reply_tpa
);
    import arp_pkg::*;

    logic frame_ok;
    logic is_local_req;

    assign frame_ok = rx_valid && rx_eth_type == ETHERTYPE_ARP &&
                      rx_htype == HTYPE_ETHERNET && rx_ptype == PTYPE_IPV4;
    assign is_local_req = rx_oper == OPER_REQUEST && rx_tpa == local_ip;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_valid    <= 1'b0;
            reply_valid <= 1'b0;
        end else begin
            wr_valid    <= frame_ok;
            reply_valid <= frame_ok && is_local_req;
        end
    end

    // learned pair and reply addressing
    always_ff @(posedge clk) begin
        wr_ip          <= rx_spa;
        wr_mac         <= rx_sha;
        reply_dest_mac <= rx_eth_src_mac;
        reply_tpa      <= rx_spa;
    end

endmodule

/* arp/arp_cache.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Direct-mapped IP to MAC table. Indexed by the low IP bits;
// a write replaces the slot, a query answers one cycle later
// with hit/miss and the stored MAC.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module arp_cache #(
    parameter int CACHE_ADDR_WIDTH = 4
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               wr_valid,
    input  arp_pkg::ip_addr_t  wr_ip,
    input  arp_pkg::mac_addr_t wr_mac,
    input  logic               query_valid,
    input  arp_pkg::ip_addr_t  query_ip,
    output logic               query_resp_valid,
    output logic               query_hit,
    output arp_pkg::mac_addr_t query_mac
);
    import arp_pkg::*;

    localparam int DEPTH = 1 << CACHE_ADDR_WIDTH;

    logic [DEPTH-1:0]            slot_valid;
    ip_addr_t                    ip_mem  [DEPTH];
    mac_addr_t                   mac_mem [DEPTH];
    logic [CACHE_ADDR_WIDTH-1:0] wr_idx;
    logic [CACHE_ADDR_WIDTH-1:0] rd_idx;

    assign wr_idx = wr_ip[CACHE_ADDR_WIDTH-1:0];
    assign rd_idx = query_ip[CACHE_ADDR_WIDTH-1:0];

    // valid bits and response strobe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot_valid       <= '0;
            query_resp_valid <= 1'b0;
        end else begin
            query_resp_valid <= query_valid;
            if (wr_valid) begin
                slot_valid[wr_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_valid) begin
            ip_mem[wr_idx]  <= wr_ip;
            mac_mem[wr_idx] <= wr_mac;
        end
    end

    // stored IP must match, the index alone aliases
    always_ff @(posedge clk) begin
        query_hit <= slot_valid[rd_idx] && ip_mem[rd_idx] == query_ip;
        query_mac <= mac_mem[rd_idx];
    end

endmodule

/* arp/arp_resolver.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Lookup FSM. Answers broadcasts at once, queries the cache
// for on-subnet IPs or the gateway, and on a miss sends paced
// request frames until a hit or the final timeout.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module arp_resolver #(
    parameter int RETRY_COUNT     = 3,
    parameter int RETRY_INTERVAL  = 64,
    parameter int REQUEST_TIMEOUT = 256
) (
    input  logic               clk,
    input  logic               rst_n,
    input  arp_pkg::ip_addr_t  gateway_ip,
    input  arp_pkg::ip_addr_t  subnet_mask,
    input  logic               request_valid,
    input  arp_pkg::ip_addr_t  request_ip,
    input  logic               query_resp_valid,
    input  logic               query_hit,
    input  arp_pkg::mac_addr_t query_mac,
    output logic               request_ready,
    output logic               response_valid,
    output logic               response_error,
    output arp_pkg::mac_addr_t response_mac,
    output logic               query_valid,
    output arp_pkg::ip_addr_t  query_ip,
    output logic               req_frame_valid,
    output arp_pkg::ip_addr_t  req_frame_tpa
);
    import arp_pkg::*;

    localparam int TIMER_MAX = (REQUEST_TIMEOUT > RETRY_INTERVAL) ?
                               REQUEST_TIMEOUT : RETRY_INTERVAL;
    localparam int TIMER_W   = $clog2(TIMER_MAX + 1);
    localparam int CNT_W     = $clog2(RETRY_COUNT + 1);

    // loaded one short so frames land exactly an interval apart
    localparam logic [TIMER_W-1:0] INTERVAL_LOAD = TIMER_W'(RETRY_INTERVAL - 1);
    localparam logic [TIMER_W-1:0] TIMEOUT_LOAD  = TIMER_W'(REQUEST_TIMEOUT - 1);

    resolver_state_t    state, state_next;
    ip_addr_t           lookup_ip, lookup_ip_next;
    logic [CNT_W-1:0]   retries_left, retries_left_next;
    logic [TIMER_W-1:0] timer, timer_next;
    logic               query_valid_next;
    logic               req_frame_valid_next;
    logic               response_valid_next;
    logic               response_error_next;
    mac_addr_t          response_mac_next;
    logic               accept;
    logic               on_subnet;
    logic               is_bcast;

    assign accept    = request_valid && request_ready;
    assign on_subnet = ((request_ip ^ gateway_ip) & subnet_mask) == '0;
    // global broadcast, or host bits all set within our subnet
    assign is_bcast  = request_ip == IP_BROADCAST ||
                       (on_subnet && (request_ip | subnet_mask) == IP_BROADCAST);

    assign query_ip      = lookup_ip;
    assign req_frame_tpa = lookup_ip;

    always_comb begin
        state_next           = state;
        lookup_ip_next       = lookup_ip;
        retries_left_next    = retries_left;
        timer_next           = timer;
        query_valid_next     = 1'b0;
        req_frame_valid_next = 1'b0;
        response_valid_next  = 1'b0;
        response_error_next  = 1'b0;
        response_mac_next    = MAC_ZERO;

        case (state)
            RES_IDLE: begin
                if (accept && is_bcast) begin
                    response_valid_next = 1'b1;
                    response_mac_next   = MAC_BROADCAST;
                end else if (accept) begin
                    lookup_ip_next   = on_subnet ? request_ip : gateway_ip;
                    query_valid_next = 1'b1;
                    state_next       = RES_QUERY;
                end
            end
            RES_QUERY: begin
                if (query_resp_valid && query_hit) begin
                    response_valid_next = 1'b1;
                    response_mac_next   = query_mac;
                    state_next          = RES_IDLE;
                end else if (query_resp_valid) begin
                    // miss, first request frame goes out now
                    req_frame_valid_next = 1'b1;
                    query_valid_next     = 1'b1;
                    retries_left_next    = CNT_W'(RETRY_COUNT - 1);
                    timer_next           = (RETRY_COUNT > 1) ? INTERVAL_LOAD : TIMEOUT_LOAD;
                    state_next           = RES_PENDING;
                end
            end
            RES_PENDING: begin
                query_valid_next = 1'b1;
                timer_next       = timer - 1'b1;
                if (query_resp_valid && query_hit) begin
                    query_valid_next    = 1'b0;
                    response_valid_next = 1'b1;
                    response_mac_next   = query_mac;
                    state_next          = RES_IDLE;
                end else if (timer == '0 && retries_left != '0) begin
                    req_frame_valid_next = 1'b1;
                    retries_left_next    = retries_left - 1'b1;
                    timer_next           = (retries_left > 1) ? INTERVAL_LOAD : TIMEOUT_LOAD;
                end else if (timer == '0) begin
                    // out of retries
                    query_valid_next    = 1'b0;
                    response_valid_next = 1'b1;
                    response_error_next = 1'b1;
                    state_next          = RES_IDLE;
                end
            end
            default: state_next = RES_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state           <= RES_IDLE;
            request_ready   <= 1'b0;
            query_valid     <= 1'b0;
            req_frame_valid <= 1'b0;
            response_valid  <= 1'b0;
            retries_left    <= '0;
            timer           <= '0;
        end else begin
            state           <= state_next;
            request_ready   <= state_next == RES_IDLE;
            query_valid     <= query_valid_next;
            req_frame_valid <= req_frame_valid_next;
            response_valid  <= response_valid_next;
            retries_left    <= retries_left_next;
            timer           <= timer_next;
        end
    end

    always_ff @(posedge clk) begin
        lookup_ip      <= lookup_ip_next;
        response_error <= response_error_next;
        response_mac   <= response_mac_next;
    end

endmodule

/* arp/arp_tx_arbiter.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Merges replies and request frames into one registered tx
// strobe. Requests win; a colliding reply waits in a
// one-entry hold and leaves on the next cycle.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module arp_tx_arbiter (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               reply_valid,
    input  arp_pkg::mac_addr_t reply_dest_mac,
    input  arp_pkg::ip_addr_t  reply_tpa,
    input  logic               req_frame_valid,
    input  arp_pkg::ip_addr_t  req_frame_tpa,
    output logic               tx_valid,
    output arp_pkg::mac_addr_t tx_dest_mac,
    output arp_pkg::arp_oper_t tx_oper,
    output arp_pkg::mac_addr_t tx_tha,
    output arp_pkg::ip_addr_t  tx_tpa
);
    import arp_pkg::*;

    logic      hold_valid;
    mac_addr_t hold_mac;
    ip_addr_t  hold_tpa;
    logic      send_hold;
    logic      load_hold;

    // held reply is older than any new one, so it goes first
    assign send_hold = hold_valid && !req_frame_valid;
    assign load_hold = reply_valid && (req_frame_valid || hold_valid);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_valid   <= 1'b0;
            hold_valid <= 1'b0;
        end else begin
            tx_valid   <= req_frame_valid || hold_valid || reply_valid;
            hold_valid <= load_hold || (hold_valid && req_frame_valid);
        end
    end

    always_ff @(posedge clk) begin
        if (load_hold) begin
            hold_mac <= reply_dest_mac;
            hold_tpa <= reply_tpa;
        end
        if (req_frame_valid) begin
            tx_dest_mac <= MAC_BROADCAST;
            tx_oper     <= OPER_REQUEST;
            tx_tha      <= MAC_ZERO;
            tx_tpa      <= req_frame_tpa;
        end else begin
            // reply target MAC is the destination MAC
            tx_dest_mac <= send_hold ? hold_mac : reply_dest_mac;
            tx_oper     <= OPER_REPLY;
            tx_tha      <= send_hold ? hold_mac : reply_dest_mac;
            tx_tpa      <= send_hold ? hold_tpa : reply_tpa;
        end
    end

endmodule

/* arp/arp_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ARP address-resolution core on parsed frame fields.
// Wires the frame handler, cache, resolver and tx arbiter;
// tx sender fields are local_mac and local_ip downstream.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module arp_top #(
    parameter int CACHE_ADDR_WIDTH = 4,
    parameter int RETRY_COUNT      = 3,
    parameter int RETRY_INTERVAL   = 64,
    parameter int REQUEST_TIMEOUT  = 256
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               rx_valid,
    input  arp_pkg::mac_addr_t rx_eth_src_mac,
    input  arp_pkg::eth_type_t rx_eth_type,
    input  arp_pkg::arp_oper_t rx_htype,
    input  arp_pkg::arp_oper_t rx_ptype,
    input  arp_pkg::arp_oper_t rx_oper,
    input  arp_pkg::mac_addr_t rx_sha,
    input  arp_pkg::ip_addr_t  rx_spa,
    input  arp_pkg::ip_addr_t  rx_tpa,
    output logic               tx_valid,
    output arp_pkg::mac_addr_t tx_dest_mac,
    output arp_pkg::arp_oper_t tx_oper,
    output arp_pkg::mac_addr_t tx_tha,
    output arp_pkg::ip_addr_t  tx_tpa,
    input  logic               request_valid,
    input  arp_pkg::ip_addr_t  request_ip,
    output logic               request_ready,
    output logic               response_valid,
    output logic               response_error,
    output arp_pkg::mac_addr_t response_mac,
    // sender MAC paired with tx frames by the serializer
    input  arp_pkg::mac_addr_t local_mac,
    input  arp_pkg::ip_addr_t  local_ip,
    input  arp_pkg::ip_addr_t  gateway_ip,
    input  arp_pkg::ip_addr_t  subnet_mask
);
    import arp_pkg::*;

    logic      wr_valid, reply_valid, query_valid, query_resp_valid;
    logic      query_hit, req_frame_valid;
    ip_addr_t  wr_ip, reply_tpa, query_ip, req_frame_tpa;
    mac_addr_t wr_mac, reply_dest_mac, query_mac;

    arp_frame_handler i_frame_handler (
        .clk, .rst_n, .local_ip,
        .rx_valid, .rx_eth_src_mac, .rx_eth_type, .rx_htype, .rx_ptype,
        .rx_oper, .rx_sha, .rx_spa, .rx_tpa,
        .wr_valid, .wr_ip, .wr_mac,
        .reply_valid, .reply_dest_mac, .reply_tpa
    );

    arp_cache #(.CACHE_ADDR_WIDTH(CACHE_ADDR_WIDTH)) i_cache (
        .clk, .rst_n, .wr_valid, .wr_ip, .wr_mac,
        .query_valid, .query_ip, .query_resp_valid, .query_hit, .query_mac
    );

    arp_resolver #(
        .RETRY_COUNT    (RETRY_COUNT),
        .RETRY_INTERVAL (RETRY_INTERVAL),
        .REQUEST_TIMEOUT(REQUEST_TIMEOUT)
    ) i_resolver (
        .clk, .rst_n, .gateway_ip, .subnet_mask,
        .request_valid, .request_ip,
        .query_resp_valid, .query_hit, .query_mac,
        .request_ready, .response_valid, .response_error, .response_mac,
        .query_valid, .query_ip, .req_frame_valid, .req_frame_tpa
    );

    arp_tx_arbiter i_tx_arbiter (
        .clk, .rst_n,
        .reply_valid, .reply_dest_mac, .reply_tpa,
        .req_frame_valid, .req_frame_tpa,
        .tx_valid, .tx_dest_mac, .tx_oper, .tx_tha, .tx_tpa
    );

endmodule

/* bench/arp_checker.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Concurrent assertions on the resolver FSM handshakes.
// Bound into every arp_resolver instance below.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module arp_checker (
    input logic                     clk,
    input logic                     rst_n,
    input arp_pkg::resolver_state_t state,
    input logic                     request_valid,
    input logic                     request_ready,
    input logic                     response_valid,
    input logic                     query_valid
);
    import arp_pkg::*;

    // ready means the resolver sits idle
    ready_only_idle: assert property (@(posedge clk) disable iff (!rst_n)
        request_ready |-> state == RES_IDLE)
        else $error("request_ready high while resolver not idle");

    // back-to-back strobes only for a request taken in the response cycle
    response_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        response_valid && !(request_valid && request_ready) |=> !response_valid)
        else $error("response_valid held longer than one cycle");

    // no cache traffic while idle
    no_query_in_idle: assert property (@(posedge clk) disable iff (!rst_n)
        query_valid |-> state != RES_IDLE)
        else $error("query_valid raised in idle state");

endmodule

bind arp_resolver arp_checker i_checker (
    .clk            (clk),
    .rst_n          (rst_n),
    .state          (state),
    .request_valid  (request_valid),
    .request_ready  (request_ready),
    .response_valid (response_valid),
    .query_valid    (query_valid)
);

/* bench/arp_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the ARP core: random frames and lookups,
// a cache model with expected tx and response values,
// and a watchdog sized from the number of lookups.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns

module arp_tb;
    import arp_pkg::*;

    localparam int CACHE_ADDR_WIDTH = 4;
    localparam int RETRY_COUNT      = 3;
    localparam int RETRY_INTERVAL   = 64;
    localparam int REQUEST_TIMEOUT  = 256;
    localparam int DEPTH            = 1 << CACHE_ADDR_WIDTH;
    localparam int CLK_PERIOD       = 4;
    localparam int NUM_TESTS        = 64;
    localparam int MISS_CYCLES      = RETRY_COUNT * RETRY_INTERVAL + REQUEST_TIMEOUT;

    logic clk, rst_n;
    logic rx_valid;
    mac_addr_t rx_eth_src_mac, rx_sha;
    eth_type_t rx_eth_type;
    arp_oper_t rx_htype, rx_ptype, rx_oper;
    ip_addr_t rx_spa, rx_tpa;
    logic tx_valid;
    mac_addr_t tx_dest_mac, tx_tha;
    arp_oper_t tx_oper;
    ip_addr_t tx_tpa;
    logic request_valid, request_ready, response_valid, response_error;
    ip_addr_t request_ip;
    mac_addr_t response_mac;
    mac_addr_t local_mac;
    ip_addr_t local_ip, gateway_ip, subnet_mask;

    // reference cache and expected tx frames
    logic         m_valid [DEPTH];
    ip_addr_t     m_ip    [DEPTH];
    mac_addr_t    m_mac   [DEPTH];
    logic [143:0] exp_tx[$];
    integer       seed = 32'hee5b_8479;

    arp_top #(
        .CACHE_ADDR_WIDTH(CACHE_ADDR_WIDTH), .RETRY_COUNT(RETRY_COUNT),
        .RETRY_INTERVAL(RETRY_INTERVAL), .REQUEST_TIMEOUT(REQUEST_TIMEOUT)
    ) i_arp_top (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(NUM_TESTS * MISS_CYCLES * CLK_PERIOD);
        $display("ERROR: watchdog expired, simulation did not finish");
        $display("*** TEST FAILED ***");
        $fatal(1);
    end

    task automatic check_value(input string what, input logic [143:0] got,
                               input logic [143:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
            $display("*** TEST FAILED ***");
            $fatal(1);
        end
    endtask

    task automatic abort_run(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    function automatic logic [143:0] pack_frame(mac_addr_t dest, arp_oper_t oper,
                                                mac_addr_t tha, ip_addr_t tpa);
        return {dest, oper, tha, tpa};
    endfunction

    function automatic mac_addr_t random_mac();
        return {16'($random(seed)), 32'($random(seed))};
    endfunction

    // on-subnet host, never gateway, local or broadcast
    function automatic ip_addr_t random_host();
        logic [7:0] host;
        host = 8'($random(seed));
        while (host == 8'd0 || host == 8'd1 || host == 8'd5 || host == 8'hff) begin
            host = 8'($random(seed));
        end
        return {24'h0a_0000, host};
    endfunction

    function automatic logic model_hit(ip_addr_t ip);
        return m_valid[ip[CACHE_ADDR_WIDTH-1:0]] && m_ip[ip[CACHE_ADDR_WIDTH-1:0]] == ip;
    endfunction

    // every tx frame must match the oldest expected one
    always @(posedge clk) begin
        if (rst_n && tx_valid) begin
            if (exp_tx.size() == 0) begin
                abort_run("tx frame seen with none expected");
            end else begin
                check_value("tx frame", {tx_dest_mac, tx_oper, tx_tha, tx_tpa},
                            exp_tx.pop_front());
            end
        end
    end

    // called 1 ns after an edge, returns 1 ns after the next
    task automatic send_frame(input mac_addr_t src, input eth_type_t etype,
                              input arp_oper_t htype, input arp_oper_t ptype,
                              input arp_oper_t oper, input ip_addr_t spa, input ip_addr_t tpa);
        int idx;
        rx_valid = 1'b1;
        rx_eth_src_mac = src;
        rx_sha = src;
        rx_eth_type = etype;
        rx_htype = htype;
        rx_ptype = ptype;
        rx_oper = oper;
        rx_spa = spa;
        rx_tpa = tpa;
        if (etype == ETHERTYPE_ARP && htype == HTYPE_ETHERNET && ptype == PTYPE_IPV4) begin
            idx = spa[CACHE_ADDR_WIDTH-1:0];
            m_valid[idx] = 1'b1;
            m_ip[idx] = spa;
            m_mac[idx] = src;
            if (oper == OPER_REQUEST && tpa == local_ip)
                exp_tx.push_back(pack_frame(src, OPER_REPLY, src, spa));
        end
        @(posedge clk);
        #1 rx_valid = 1'b0;
    endtask

    task automatic learn(input mac_addr_t mac, input ip_addr_t ip);
        send_frame(mac, ETHERTYPE_ARP, HTYPE_ETHERNET, PTYPE_IPV4, OPER_REPLY, ip, local_ip);
    endtask

    // latency below zero means it is not checked
    task automatic lookup(input ip_addr_t ip, input logic exp_err,
                          input mac_addr_t exp_mac, input int exp_lat);
        int cycles;
        while (!request_ready) begin
            @(posedge clk);
            #1;
        end
        request_valid = 1'b1;
        request_ip = ip;
        @(posedge clk);
        #1 request_valid = 1'b0;
        cycles = 1;
        while (!response_valid) begin
            check_value("request_ready while busy", request_ready, 1'b0);
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > MISS_CYCLES + 20) abort_run("no lookup response before timeout");
        end
        check_value("request_ready at response", request_ready, 1'b1);
        check_value("response_error", response_error, exp_err);
        if (!exp_err) check_value("response_mac", response_mac, exp_mac);
        if (exp_lat >= 0) check_value("response latency", cycles, exp_lat);
    endtask

    initial begin
        ip_addr_t ip, mask, target;
        mac_addr_t mac, gw_mac;
        int len;
        for (int i = 0; i < DEPTH; i++) m_valid[i] = 1'b0;
        {rx_valid, request_valid} = '0;
        {rx_eth_src_mac, rx_sha, rx_eth_type, rx_htype, rx_ptype} = '0;
        {rx_oper, rx_spa, rx_tpa, request_ip} = '0;
        local_mac = 48'h02_00_00_00_00_05;
        local_ip = 32'h0a00_0005;
        gateway_ip = 32'h0a00_0001;
        subnet_mask = 32'hffff_ff00;
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        #1 rst_n = 1'b1;
        @(posedge clk);
        #1;
        check_value("request_ready after reset", request_ready, 1'b1);

        // broadcasts, global and per random mask
        lookup(IP_BROADCAST, 1'b0, MAC_BROADCAST, 1);
        for (int i = 0; i < 6; i++) begin
            len = 8 + ($unsigned($random(seed)) % 23);
            mask = 32'hffff_ffff << (32 - len);
            subnet_mask = mask;
            lookup((gateway_ip & mask) | ~mask, 1'b0, MAC_BROADCAST, 1);
        end
        subnet_mask = 32'hffff_ff00;

        // requests for local_ip, back to back, plus rejected frames
        for (int i = 0; i < 6; i++) begin
            send_frame(random_mac(), ETHERTYPE_ARP, HTYPE_ETHERNET, PTYPE_IPV4,
                       OPER_REQUEST, random_host(), local_ip);
        end
        send_frame(random_mac(), 16'h0800, HTYPE_ETHERNET, PTYPE_IPV4,
                   OPER_REQUEST, random_host(), local_ip);
        send_frame(random_mac(), ETHERTYPE_ARP, 16'h0006, PTYPE_IPV4,
                   OPER_REQUEST, random_host(), local_ip);
        send_frame(random_mac(), ETHERTYPE_ARP, HTYPE_ETHERNET, 16'h86dd,
                   OPER_REQUEST, random_host(), local_ip);
        send_frame(random_mac(), ETHERTYPE_ARP, HTYPE_ETHERNET, PTYPE_IPV4,
                   OPER_REQUEST, random_host(), 32'h0a00_0063);
        repeat (6) @(posedge clk);
        #1;

        // learning with index collisions, then hits
        for (int i = 0; i < 24; i++) learn(random_mac(), random_host());
        @(posedge clk);
        #1;
        for (int i = 0; i < DEPTH; i++) begin
            if (m_valid[i]) lookup(m_ip[i], 1'b0, m_mac[i], 3);
        end

        // off-subnet through the gateway
        gw_mac = random_mac();
        learn(gw_mac, gateway_ip);
        @(posedge clk);
        #1;
        for (int i = 0; i < 4; i++) begin
            ip = {8'hc0, 24'($random(seed))};
            lookup(ip, 1'b0, gw_mac, 3);
        end

        // full miss, then a miss answered after the first request frame
        target = random_host();
        while (model_hit(target)) target = random_host();
        for (int i = 0; i < RETRY_COUNT; i++)
            exp_tx.push_back(pack_frame(MAC_BROADCAST, OPER_REQUEST, MAC_ZERO, target));
        lookup(target, 1'b1, MAC_ZERO, -1);
        check_value("tx frames left after miss", exp_tx.size(), 0);

        target = random_host();
        while (model_hit(target)) target = random_host();
        mac = random_mac();
        exp_tx.push_back(pack_frame(MAC_BROADCAST, OPER_REQUEST, MAC_ZERO, target));
        fork
            lookup(target, 1'b0, mac, -1);
            begin
                @(posedge clk);
                while (!tx_valid) @(posedge clk);
                #1;
                learn(mac, target);
            end
        join

        repeat (10) @(posedge clk);
        check_value("tx frames left at end", exp_tx.size(), 0);
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

/* project.f */
common/arp_pkg.sv
arp/arp_frame_handler.sv
arp/arp_cache.sv
arp/arp_resolver.sv
arp/arp_tx_arbiter.sv
arp/arp_top.sv
bench/arp_checker.sv
bench/arp_tb.sv

/* Makefile */
# Verilator build and run for the ARP core testbench

VERILATOR  ?= verilator
TOP        ?= arp_tb
FILELIST   ?= project.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -Wno-fatal
PASS_TEXT  ?= *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, check for the pass message"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(OBJ_DIR)/V$(TOP)
	@out="$$($(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_TEXT)'

clean:
	rm -rf $(OBJ_DIR)
